/* spriteArt.hex */
// 4x4 sprite, one 24-bit RGB word per line (rrggbb), row major from the top-left
// 000000 is transparent
000000
c02010
c02020
000000
c03010
f0e030
f0e040
c03020
c04010
f0e050
f0e060
c04020
000000
20c040
20c050
000000

/* spriteScene.f */
videoPkg.sv
spritePkg.sv
rasterScan.sv
coordFifo.sv
spriteRom.sv
spriteRender.sv
spriteMotion.sv
spriteScene.sv
tbClock.sv
spriteScene_sva.sv
spriteScene_tb.sv

/* run.sh */
#!/bin/sh
# build and run the spriteScene testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module spriteScene_tb -f spriteScene.f -o simv
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* spriteScene_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module spriteScene_tb;
  import videoPkg::*;
  import spritePkg::*;

  localparam int FRAME_W        = 16;
  localparam int FRAME_H        = 12;
  localparam int FIFO_DEPTH     = 4;
  localparam int REVERSE_FRAMES = 3;
  localparam int PIXELS         = FRAME_W * FRAME_H;
  localparam int TOTAL_FRAMES   = 17;
  // 8 cycles per pixel for stall, 20 ns per cycle, plus reset
  localparam int TIMEOUT_NS     = TOTAL_FRAMES * PIXELS * 8 * 20 + 1000;

  logic       clk;
  logic       reset;
  logic       scanEnable;
  logic       motionEnable;
  logic       pixelReady;
  spritePos_t initPos;
  pixel_t     pixelOut;
  logic       pixelValid;

  // reference model state
  rgb_t        artModel [SPRITE_WORDS];
  logic [31:0] lcgState;
  int          expX;
  int          expY;
  int          posX;
  int          posY;
  logic        movingUpRight;
  int          moveCount;
  int          stretchLeft;
  int          checks;
  int          errors;
  int          testErrors;

  tbClock clockGen (
    .clk  (clk),
    .reset(reset)
  );

  spriteScene #(
    .FRAME_W       (FRAME_W),
    .FRAME_H       (FRAME_H),
    .FIFO_DEPTH    (FIFO_DEPTH),
    .REVERSE_FRAMES(REVERSE_FRAMES)
  ) DUT (
    .clk         (clk),
    .reset       (reset),
    .scanEnable  (scanEnable),
    .motionEnable(motionEnable),
    .initPos     (initPos),
    .pixelOut    (pixelOut),
    .pixelValid  (pixelValid),
    .pixelReady  (pixelReady)
  );

  // LCG, upper half used as the draw
  function automatic int randBelow(input int limit);
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return int'(lcgState[31:16]) % limit;
  endfunction

  task automatic checkPixel(input pixel_t got, input pixel_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      testErrors++;
      $display("mismatch pixelOut got %h expected %h", got, exp);
    end
  endtask

  task automatic checkPos(input spritePos_t got, input spritePos_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      testErrors++;
      $display("mismatch spritePos got %h expected %h", got, exp);
    end
  endtask

  // box test and ROM lookup against the current frame position
  function automatic pixel_t expectedPixel(input int x, input int y);
    pixel_t p;
    int     col;
    int     row;
    rgb_t   word;
    col      = x - posX;
    row      = y - posY;
    p.x      = coordX_t'(x);
    p.y      = coordY_t'(y);
    p.hit    = 1'b0;
    p.colour = '0;
    if (col >= 0 && col < SPRITE_W && row >= 0 && row < SPRITE_H) begin
      word = artModel[row * SPRITE_W + col];
      if (word != '0) begin
        p.hit    = 1'b1;
        p.colour = word;
      end
    end
    return p;
  endfunction

  // diagonal step with clamping, turn after REVERSE_FRAMES moves
  task automatic advanceMotion();
    if (motionEnable) begin
      if (movingUpRight) begin
        posX = (posX + 1 > FRAME_W - SPRITE_W) ? FRAME_W - SPRITE_W : posX + 1;
        posY = (posY == 0) ? 0 : posY - 1;
      end else begin
        posX = (posX == 0) ? 0 : posX - 1;
        posY = (posY + 1 > FRAME_H - SPRITE_H) ? FRAME_H - SPRITE_H : posY + 1;
      end
      moveCount++;
      if (moveCount == REVERSE_FRAMES) begin
        moveCount     = 0;
        movingUpRight = !movingUpRight;
      end
    end
  endtask

  // check a transfer due at the next edge, then drive after that edge
  task automatic runCycle(input int stallPct, output logic frameEnded);
    spritePos_t expPos;
    frameEnded = 1'b0;
    @(negedge clk);
    if (pixelValid && pixelReady) begin
      checkPixel(pixelOut, expectedPixel(expX, expY));
      if (expX == FRAME_W - 1 && expY == FRAME_H - 1) begin
        expX = 0;
        expY = 0;
        advanceMotion();
        // DUT moved the box when the last coordinate entered the renderer
        expPos.x = coordX_t'(posX);
        expPos.y = coordY_t'(posY);
        checkPos(DUT.spritePos, expPos);
        frameEnded = 1'b1;
      end else if (expX == FRAME_W - 1) begin
        expX = 0;
        expY++;
      end else begin
        expX++;
      end
    end
    @(posedge clk);
    #1;
    scanEnable = (randBelow(100) < 75);
    // ready held for stretches of 1 to 6 cycles
    if (stretchLeft == 0) begin
      pixelReady  = (randBelow(100) >= stallPct);
      stretchLeft = 1 + randBelow(6);
    end
    stretchLeft--;
  endtask

  // motion enable only changes at a frame boundary
  task automatic runTest(input string name, input int frames, input int stallPct,
                         input logic motion);
    int   done;
    logic ended;
    testErrors   = 0;
    done         = 0;
    motionEnable = motion;
    while (done < frames) begin
      runCycle(stallPct, ended);
      if (ended) begin
        done++;
      end
    end
    $display("test %s: %0d frames, %0d errors", name, frames, testErrors);
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: not all frames came out of the pixel stream in time");
    $display("Finished with errors");
    $finish;
  end

  initial begin
    $readmemh("spriteArt.hex", artModel);
    lcgState      = 32'h017a_68fd;
    checks        = 0;
    errors        = 0;
    stretchLeft   = 0;
    scanEnable    = 1'b0;
    motionEnable  = 1'b0;
    pixelReady    = 1'b1;
    // legal corner at the top-right edge, so the first up-right steps clamp
    initPos.x     = coordX_t'(FRAME_W - SPRITE_W - randBelow(2));
    initPos.y     = coordY_t'(randBelow(2));
    posX          = int'(initPos.x);
    posY          = int'(initPos.y);
    movingUpRight = 1'b1;
    moveCount     = 0;
    expX          = 0;
    expY          = 0;
    @(negedge reset);

    if (pixelValid !== 1'b0) begin
      errors++;
      $display("pixelValid is not low after reset");
    end
    checkPos(DUT.spritePos, initPos);
    runTest("reset", 1, 20, 1'b0);
    runTest("frozen motion", 2, 20, 1'b0);
    checkPos(DUT.spritePos, initPos);
    runTest("raster order", 2, 20, 1'b1);
    runTest("sprite colour", 2, 10, 1'b1);
    runTest("back-pressure", 2, 60, 1'b1);
    runTest("motion", 8, 20, 1'b1);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* spriteScene_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module renderChecks (
  input logic             clk,
  input logic             reset,
  input videoPkg::pixel_t pixelOut,
  input logic             pixelValid,
  input logic             pixelReady,
  input logic             frameDone
);

  // stalled pixel keeps valid and data
  holdUnderStall: assert property (@(posedge clk) disable iff (reset)
    pixelValid && !pixelReady |=> pixelValid && $stable(pixelOut))
    else $error("pixel output changed while stalled");

  // one pulse per frame end
  frameDonePulse: assert property (@(posedge clk) disable iff (reset)
    frameDone |=> !frameDone)
    else $error("frameDone high for two cycles");

  // output slot empty out of reset
  // nothing reaches it before a coordinate has crossed both stages
  validLowAfterReset: assert property (@(posedge clk)
    $fell(reset) |-> !pixelValid ##1 !pixelValid ##1 !pixelValid)
    else $error("pixelValid high too early after reset");

endmodule

bind spriteRender renderChecks checks (
  .clk       (clk),
  .reset     (reset),
  .pixelOut  (pixelOut),
  .pixelValid(pixelValid),
  .pixelReady(pixelReady),
  .frameDone (frameDone)
);

`default_nettype wire

/* tbClock.sv */
`timescale 1ns/1ns
`default_nettype none

module tbClock #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // release just after an edge, same as the other stimulus
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

`default_nettype wire

/* spriteScene.sv */
`timescale 1ns/1ns
`default_nettype none

module spriteScene #(
  parameter int FRAME_W        = 16,
  parameter int FRAME_H        = 12,
  parameter int FIFO_DEPTH     = 4,
  parameter int REVERSE_FRAMES = 3
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  scanEnable,
  input  logic                  motionEnable,
  input  spritePkg::spritePos_t initPos,
  output videoPkg::pixel_t      pixelOut,
  output logic                  pixelValid,
  input  logic                  pixelReady
);
  import videoPkg::*;
  import spritePkg::*;

  // scanner to FIFO
  coord_t     scanCoord;
  logic       scanValid;
  logic       scanReady;
  // FIFO to renderer
  coord_t     fifoCoord;
  logic       fifoValid;
  logic       fifoReady;
  // renderer side channels
  spritePos_t spritePos;
  romAddr_t   romAddr;
  rgb_t       romData;
  logic       frameDone;

  rasterScan #(
    .FRAME_W(FRAME_W),
    .FRAME_H(FRAME_H)
  ) scan (
    .clk       (clk),
    .reset     (reset),
    .scanEnable(scanEnable),
    .coordOut  (scanCoord),
    .coordValid(scanValid),
    .coordReady(scanReady)
  );

  coordFifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) fifo (
    .clk     (clk),
    .reset   (reset),
    .inData  (scanCoord),
    .inValid (scanValid),
    .inReady (scanReady),
    .outData (fifoCoord),
    .outValid(fifoValid),
    .outReady(fifoReady)
  );

  spriteRender render (
    .clk       (clk),
    .reset     (reset),
    .coordIn   (fifoCoord),
    .coordValid(fifoValid),
    .coordReady(fifoReady),
    .spritePos (spritePos),
    .romAddr   (romAddr),
    .romData   (romData),
    .frameDone (frameDone),
    .pixelOut  (pixelOut),
    .pixelValid(pixelValid),
    .pixelReady(pixelReady)
  );

  spriteRom rom (
    .clk (clk),
    .addr(romAddr),
    .data(romData)
  );

  spriteMotion #(
    .FRAME_W       (FRAME_W),
    .FRAME_H       (FRAME_H),
    .REVERSE_FRAMES(REVERSE_FRAMES)
  ) motion (
    .clk         (clk),
    .reset       (reset),
    .initPos     (initPos),
    .motionEnable(motionEnable),
    .frameDone   (frameDone),
    .spritePos   (spritePos)
  );

endmodule

`default_nettype wire

/* spriteMotion.sv */
`timescale 1ns/1ns
`default_nettype none

module spriteMotion #(
  parameter int FRAME_W        = 16,
  parameter int FRAME_H        = 12,
  parameter int REVERSE_FRAMES = 3
) (
  input  logic                  clk,
  input  logic                  reset,
  input  spritePkg::spritePos_t initPos,
  input  logic                  motionEnable,
  input  logic                  frameDone,
  output spritePkg::spritePos_t spritePos
);
  import videoPkg::*;
  import spritePkg::*;

  // top-left limits that keep the whole box inside the frame
  localparam coordX_t X_MAX = coordX_t'(FRAME_W - SPRITE_W);
  localparam coordY_t Y_MAX = coordY_t'(FRAME_H - SPRITE_H);
  localparam int      CNT_W = $clog2(REVERSE_FRAMES + 1);

  dir_t             dir;
  logic [CNT_W-1:0] moveCount;
  logic             step;
  coordX_t          nextX;
  coordY_t          nextY;

  assign step = frameDone && motionEnable;

  // one diagonal step, each axis saturates at its limit
  always_comb begin
    if (dir == dirUpRight) begin
      nextX = (spritePos.x >= X_MAX) ? X_MAX : spritePos.x + 1'b1;
      nextY = (spritePos.y == '0) ? '0 : spritePos.y - 1'b1;
    end else begin
      nextX = (spritePos.x == '0) ? '0 : spritePos.x - 1'b1;
      nextY = (spritePos.y >= Y_MAX) ? Y_MAX : spritePos.y + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      // start position sampled while reset is held
      spritePos <= initPos;
      dir       <= dirUpRight;
      moveCount <= '0;
    end else if (step) begin
      spritePos.x <= nextX;
      spritePos.y <= nextY;
      // clamped steps still count toward the turn
      if (moveCount == CNT_W'(REVERSE_FRAMES - 1)) begin
        moveCount <= '0;
        dir       <= (dir == dirUpRight) ? dirDownLeft : dirUpRight;
      end else begin
        moveCount <= moveCount + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* spriteRender.sv */
`timescale 1ns/1ns
`default_nettype none

module spriteRender (
  input  logic                  clk,
  input  logic                  reset,
  input  videoPkg::coord_t      coordIn,
  input  logic                  coordValid,
  output logic                  coordReady,
  input  spritePkg::spritePos_t spritePos,
  output spritePkg::romAddr_t   romAddr,
  input  videoPkg::rgb_t        romData,
  output logic                  frameDone,
  output videoPkg::pixel_t      pixelOut,
  output logic                  pixelValid,
  input  logic                  pixelReady
);
  import videoPkg::*;
  import spritePkg::*;

  // offsets into the box, wrap large when left of or above the sprite
  coordX_t  colOff;
  coordY_t  rowOff;
  logic     inBox;
  romAddr_t addrNext;
  logic     advance;
  logic     accept;
  logic     romHit;

  // stage one: box test result and ROM address
  logic     s1Valid;
  coordX_t  s1X;
  coordY_t  s1Y;
  logic     s1Inside;
  romAddr_t s1Addr;

  // ROM wait slot, lines up with the word coming back
  logic     s2Valid;
  coordX_t  s2X;
  coordY_t  s2Y;
  logic     s2Inside;
  romAddr_t s2Addr;

  // whole pipe moves when the output slot is empty or being taken
  assign advance    = !pixelValid || pixelReady;
  assign coordReady = advance;
  assign accept     = coordValid && advance;

  assign colOff = coordIn.x - spritePos.x;
  assign rowOff = coordIn.y - spritePos.y;
  assign inBox  = (coordIn.x >= spritePos.x) && (colOff < coordX_t'(SPRITE_W)) &&
                  (coordIn.y >= spritePos.y) && (rowOff < coordY_t'(SPRITE_H));
  assign addrNext = romAddr_t'(rowOff * SPRITE_W + colOff);

  // one cycle per frame, motion updates on this edge
  assign frameDone = accept && coordIn.frameEnd;

  // under stall the ROM rereads the word of the waiting item
  assign romAddr = advance ? s1Addr : s2Addr;

  // transparent words count as a miss
  assign romHit = s2Inside && (romData != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      s1Valid    <= 1'b0;
      s2Valid    <= 1'b0;
      pixelValid <= 1'b0;
    end else if (advance) begin
      s1Valid    <= coordValid;
      s2Valid    <= s1Valid;
      pixelValid <= s2Valid;
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (advance) begin
      s1X      <= coordIn.x;
      s1Y      <= coordIn.y;
      s1Inside <= inBox;
      s1Addr   <= addrNext;
      s2X      <= s1X;
      s2Y      <= s1Y;
      s2Inside <= s1Inside;
      s2Addr   <= s1Addr;
      pixelOut.x      <= s2X;
      pixelOut.y      <= s2Y;
      pixelOut.hit    <= romHit;
      pixelOut.colour <= romHit ? romData : '0;
    end
  end

endmodule

`default_nettype wire

/* spriteRom.sv */
`timescale 1ns/1ns
`default_nettype none

module spriteRom (
  input  logic                clk,
  input  spritePkg::romAddr_t addr,
  output videoPkg::rgb_t      data
);
  import videoPkg::*;
  import spritePkg::*;

  // sprite art, row major, zero words are transparent
  rgb_t art [SPRITE_WORDS];

  initial begin
    $readmemh("spriteArt.hex", art);
  end

  // registered read, word appears one cycle after the address
  always_ff @(posedge clk) begin
    data <= art[addr];
  end

endmodule

`default_nettype wire

/* coordFifo.sv */
`timescale 1ns/1ns
`default_nettype none

module coordFifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  videoPkg::coord_t inData,
  input  logic             inValid,
  output logic             inReady,
  output videoPkg::coord_t outData,
  output logic             outValid,
  input  logic             outReady
);
  import videoPkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  coord_t           mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;
  logic             doWrite;
  logic             doRead;

  // pointer step with wrap, depth need not be a power of two
  function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign inReady  = (count != CNT_W'(FIFO_DEPTH));
  assign outValid = (count != '0);
  assign outData  = mem[rdPtr];
  assign doWrite  = inValid && inReady;
  assign doRead   = outValid && outReady;

  // written entry is visible at the head one cycle later
  always_ff @(posedge clk) begin
    if (doWrite) begin
      mem[wrPtr] <= inData;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doWrite) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (doRead) begin
        rdPtr <= nextPtr(rdPtr);
      end
      // simultaneous push and pop keeps the count
      case ({doWrite, doRead})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rasterScan.sv */
`timescale 1ns/1ns
`default_nettype none

module rasterScan #(
  parameter int FRAME_W = 16,
  parameter int FRAME_H = 12
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             scanEnable,
  output videoPkg::coord_t coordOut,
  output logic             coordValid,
  input  logic             coordReady
);
  import videoPkg::*;

  // last column and row of the frame
  localparam coordX_t LAST_X = coordX_t'(FRAME_W - 1);
  localparam coordY_t LAST_Y = coordY_t'(FRAME_H - 1);

  coordX_t xCount;
  coordY_t yCount;
  logic    lastPixel;
  logic    transfer;

  assign lastPixel = (xCount == LAST_X) && (yCount == LAST_Y);
  assign transfer  = coordValid && coordReady;

  // offer comes straight from the counters
  // counters only move on a transfer, so a stalled offer stays put
  assign coordOut.x        = xCount;
  assign coordOut.y        = yCount;
  assign coordOut.frameEnd = lastPixel;

  always_ff @(posedge clk) begin
    if (reset) begin
      xCount     <= '0;
      yCount     <= '0;
      coordValid <= 1'b0;
    end else begin
      // valid only follows the enable once the pending offer is gone
      if (!coordValid || coordReady) begin
        coordValid <= scanEnable;
      end
      if (transfer) begin
        if (xCount == LAST_X) begin
          xCount <= '0;
          // wrap to (0,0) right after the last pixel, no idle cycle
          if (yCount == LAST_Y) begin
            yCount <= '0;
          end else begin
            yCount <= yCount + 1'b1;
          end
        end else begin
          xCount <= xCount + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* spritePkg.sv */
`default_nettype none

package spritePkg;

  // sprite size, tied to the art in spriteArt.hex
  localparam int SPRITE_W = 4;
  localparam int SPRITE_H = 4;

  // one ROM word per sprite pixel, row major
  localparam int SPRITE_WORDS = SPRITE_W * SPRITE_H;

  typedef logic [3:0] romAddr_t;

  // diagonal motion, up-right moves x+1 and y-1
  typedef enum logic {
    dirDownLeft = 1'b0,
    dirUpRight  = 1'b1
  } dir_t;

  // top-left corner of the sprite box
  typedef struct packed {
    videoPkg::coordX_t x;
    videoPkg::coordY_t y;
  } spritePos_t;

endpackage

`default_nettype wire

/* videoPkg.sv */
`default_nettype none

package videoPkg;

  // raster coordinates, wide enough for a full 640x480 frame
  typedef logic [9:0] coordX_t;
  typedef logic [8:0] coordY_t;

  // one colour word, red in the top byte
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

  // coordinate record from the scanner
  // frameEnd marks the bottom-right pixel
  typedef struct packed {
    coordX_t x;
    coordY_t y;
    logic    frameEnd;
  } coord_t;

  // rendered pixel, colour is zero when hit is clear
  typedef struct packed {
    coordX_t x;
    coordY_t y;
    logic    hit;
    rgb_t    colour;
  } pixel_t;

endpackage

`default_nettype wire
